// ==== hw/exPkg.sv ====
//------------------------------------------------
// Execute stage package.
// Datapath width, function and branch encodings,
// and the control, flag and EX/MEM payload types.
//------------------------------------------------

package exPkg;

    localparam int DataWidth = 32; // Datapath width.

    // ------------------------------------------------
    // Encodings
    // ------------------------------------------------

    typedef enum logic [4:0] {
        FnAdd,   // Signed add, flags overflow.
        FnAddu,
        FnSub,   // Signed subtract, flags overflow.
        FnSubu,
        FnAnd,
        FnOr,
        FnXor,
        FnNor,
        FnSlt,   // Signed set-less-than.
        FnSltu,
        FnSll,   // Shifts by shamt.
        FnSrl,
        FnSra,
        FnSllv,  // Shifts by a[4:0].
        FnSrlv,
        FnSrav,
        FnLui,
        FnMult,  // Load HI/LO with product.
        FnMultu,
        FnMadd,  // Add product into HI/LO.
        FnMfhi,
        FnMflo
    } exFunc_e;

    typedef enum logic [1:0] {
        BrNone,
        BrEq,
        BrNe,
        BrJump
    } branchKind_e;

    // ------------------------------------------------
    // Structs
    // ------------------------------------------------

    typedef struct packed {
        logic        regWrite;
        logic        memRead;
        logic        memToReg;
        logic        memWrite;
        logic        aluSrc;    // Immediate replaces B.
        branchKind_e branch;
        exFunc_e     func;
    } exCtrl_t;

    typedef struct packed {
        logic c; // Carry out.
        logic z; // Zero.
        logic o; // Signed overflow.
        logic n; // Negative.
    } exFlags_t;

    typedef struct packed {
        logic [DataWidth-1:0] result;
        logic [DataWidth-1:0] rtData;     // Store data.
        logic [DataWidth-1:0] pcOut;      // Next program counter.
        logic [4:0]           rAddr;      // Destination register.
        exFlags_t             flags;
        logic                 regWrite;
        logic                 memRead;
        logic                 memToReg;
        logic                 memWrite;
        logic                 branchTaken;
    } exResult_t;

endpackage

// ==== hw/exAlu.sv ====
//------------------------------------------------
// Execute stage ALU.
// Arithmetic, logic, compare and shift functions
// with carry, zero, overflow and negative flags.
// Purely combinational.
//------------------------------------------------

`timescale 1ns/1ps

module exAlu (
    input  logic [exPkg::DataWidth-1:0] a,        // Operand A.
    input  logic [exPkg::DataWidth-1:0] y,        // B or immediate.
    input  logic [4:0]                  shamt,    // Fixed shift amount.
    input  exPkg::exFunc_e              func,
    output logic [exPkg::DataWidth-1:0] aluOut,
    output exPkg::exFlags_t             aluFlags
);

    localparam int Msb = exPkg::DataWidth - 1;

    logic [exPkg::DataWidth:0] sum;    // Carry in top bit.
    logic [exPkg::DataWidth:0] diff;   // Inverted borrow in top bit.
    logic                      addOvf;
    logic                      subOvf;
    logic                      ltSigned;
    logic                      ltUnsigned;
    logic [4:0]                varAmt; // Variable shift amount.
    logic                      carry;
    logic                      ovf;

    // ------------------------------------------------
    // Adder and compare
    // ------------------------------------------------

    assign sum  = {1'b0, a} + {1'b0, y};
    assign diff = {1'b0, a} + {1'b0, ~y} + (exPkg::DataWidth+1)'(1);

    // Operands agree in sign but result does not.
    assign addOvf = (a[Msb] == y[Msb]) && (sum[Msb] != a[Msb]);
    assign subOvf = (a[Msb] != y[Msb]) && (diff[Msb] != a[Msb]);

    assign ltSigned   = $signed(a) < $signed(y);
    assign ltUnsigned = ~diff[exPkg::DataWidth]; // Borrow means a < y.
    assign varAmt     = a[4:0];

    // ------------------------------------------------
    // Function select
    // ------------------------------------------------

    always_comb begin
        aluOut = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (func)
            exPkg::FnAdd: begin
                aluOut = sum[Msb:0];
                carry  = sum[exPkg::DataWidth];
                ovf    = addOvf;
            end
            exPkg::FnAddu: begin
                aluOut = sum[Msb:0];
                carry  = sum[exPkg::DataWidth];
            end
            exPkg::FnSub: begin
                aluOut = diff[Msb:0];
                carry  = diff[exPkg::DataWidth];
                ovf    = subOvf;
            end
            exPkg::FnSubu: begin
                aluOut = diff[Msb:0];
                carry  = diff[exPkg::DataWidth];
            end
            exPkg::FnAnd:  aluOut = a & y;
            exPkg::FnOr:   aluOut = a | y;
            exPkg::FnXor:  aluOut = a ^ y;
            exPkg::FnNor:  aluOut = ~(a | y);
            exPkg::FnSlt:  aluOut = {{Msb{1'b0}}, ltSigned};
            exPkg::FnSltu: aluOut = {{Msb{1'b0}}, ltUnsigned};
            exPkg::FnSll:  aluOut = y << shamt;
            exPkg::FnSrl:  aluOut = y >> shamt;
            exPkg::FnSra:  aluOut = $unsigned($signed(y) >>> shamt);
            exPkg::FnSllv: aluOut = y << varAmt;
            exPkg::FnSrlv: aluOut = y >> varAmt;
            exPkg::FnSrav: aluOut = $unsigned($signed(y) >>> varAmt);
            exPkg::FnLui:  aluOut = y << 16; // Immediate to upper half.
            default:       aluOut = '0;      // Accumulator functions.
        endcase
    end

    assign aluFlags = '{c: carry, z: (aluOut == '0), o: ovf, n: aluOut[Msb]};

endmodule

// ==== hw/exMulAccum.sv ====
//------------------------------------------------
// Multiply-accumulate unit.
// Signed and unsigned 32x32 multiply into a 64-bit
// HI/LO register, multiply-add, and HI/LO moves.
//------------------------------------------------

`timescale 1ns/1ps

module exMulAccum (
    input  logic                        Clock,
    input  logic                        arstN,
    input  logic                        accEn,  // Write HI/LO this cycle.
    input  exPkg::exFunc_e              func,
    input  logic [exPkg::DataWidth-1:0] a,
    input  logic [exPkg::DataWidth-1:0] y,
    output logic [exPkg::DataWidth-1:0] accOut, // HI or LO word.
    output exPkg::exFlags_t             accFlags
);

    localparam int Dw       = exPkg::DataWidth;
    localparam int AccWidth = 2 * Dw;

    logic [AccWidth-1:0] hiLo;         // HI in upper half.
    logic [AccWidth-1:0] prodSigned;
    logic [AccWidth-1:0] prodUnsigned;
    logic [AccWidth-1:0] product;
    logic [AccWidth-1:0] nextHiLo;
    logic [AccWidth-1:0] viewHiLo;     // Value seen by result and flags.

    // ------------------------------------------------
    // Multiplier
    // ------------------------------------------------

    // Low 64 bits of the widened product give the signed result.
    assign prodSigned   = {{Dw{a[Dw-1]}}, a} * {{Dw{y[Dw-1]}}, y};
    assign prodUnsigned = {{Dw{1'b0}}, a} * {{Dw{1'b0}}, y};

    assign product  = (func == exPkg::FnMultu) ? prodUnsigned : prodSigned;
    assign nextHiLo = (func == exPkg::FnMadd) ? (hiLo + product) : product;

    // ------------------------------------------------
    // HI/LO register
    // ------------------------------------------------

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            hiLo <= '0;
        end else if (accEn) begin
            hiLo <= nextHiLo; // Visible to a move next cycle.
        end
    end

    // Writes report the new value, moves report the held one.
    assign viewHiLo = accEn ? nextHiLo : hiLo;

    assign accOut = (func == exPkg::FnMfhi) ? viewHiLo[AccWidth-1:Dw]
                                            : viewHiLo[Dw-1:0];

    assign accFlags = '{
        c: 1'b0,
        z: (viewHiLo == '0),      // Whole 64 bits.
        o: 1'b0,
        n: viewHiLo[AccWidth-1]
    };

endmodule

// ==== hw/exControl.sv ====
//------------------------------------------------
// Execute stage control.
// Selects result and flag source, resolves branches
// and jumps, and builds the EX/MEM payload.
//------------------------------------------------

`timescale 1ns/1ps

module exControl (
    input  exPkg::exCtrl_t              ctrl,
    input  logic [exPkg::DataWidth-1:0] pcIn,
    input  logic [exPkg::DataWidth-1:0] immediate,
    input  logic [exPkg::DataWidth-1:0] b,          // Store data.
    input  logic [4:0]                  rAddrIn,
    input  logic [exPkg::DataWidth-1:0] aluOut,
    input  exPkg::exFlags_t             aluFlags,
    input  logic [exPkg::DataWidth-1:0] accOut,
    input  exPkg::exFlags_t             accFlags,
    output logic                        accEn,      // HI/LO write enable.
    output exPkg::exResult_t            nextResult
);

    logic                        isMove;   // MFHI or MFLO.
    logic                        useAcc;   // Result from accumulator.
    logic                        isBranch;
    logic                        taken;
    logic [exPkg::DataWidth-1:0] pcPlus4;
    logic [exPkg::DataWidth-1:0] brTarget;
    logic [exPkg::DataWidth-1:0] pcNext;

    // ------------------------------------------------
    // Function decode
    // ------------------------------------------------

    always_comb begin
        accEn  = 1'b0;
        isMove = 1'b0;
        case (ctrl.func)
            exPkg::FnMult,
            exPkg::FnMultu,
            exPkg::FnMadd: accEn  = 1'b1;
            exPkg::FnMfhi,
            exPkg::FnMflo: isMove = 1'b1;
            default: begin
                accEn  = 1'b0;
                isMove = 1'b0;
            end
        endcase
    end

    assign useAcc = accEn | isMove;

    // ------------------------------------------------
    // Branch resolution
    // ------------------------------------------------

    always_comb begin
        case (ctrl.branch)
            exPkg::BrEq:   taken = aluFlags.z;  // Compare done by SUB.
            exPkg::BrNe:   taken = ~aluFlags.z;
            exPkg::BrJump: taken = 1'b1;
            default:       taken = 1'b0;
        endcase
    end

    assign isBranch = (ctrl.branch != exPkg::BrNone);
    assign pcPlus4  = pcIn + exPkg::DataWidth'(4);
    assign brTarget = pcPlus4 + (immediate << 2); // Word offset.

    always_comb begin
        if (!taken) begin
            pcNext = pcPlus4;
        end else if (ctrl.branch == exPkg::BrJump) begin
            pcNext = immediate; // Absolute target.
        end else begin
            pcNext = brTarget;
        end
    end

    // ------------------------------------------------
    // Payload
    // ------------------------------------------------

    always_comb begin
        nextResult.result      = useAcc ? accOut : aluOut;
        nextResult.flags       = useAcc ? accFlags : aluFlags;
        nextResult.rtData      = b;
        nextResult.pcOut       = pcNext;
        nextResult.rAddr       = rAddrIn;
        nextResult.regWrite    = ctrl.regWrite & ~isBranch; // No writeback on branch.
        nextResult.memRead     = ctrl.memRead;
        nextResult.memToReg    = ctrl.memToReg;
        nextResult.memWrite    = ctrl.memWrite;
        nextResult.branchTaken = taken;
    end

endmodule

// ==== hw/exMemReg.sv ====
//------------------------------------------------
// EX/MEM pipeline register.
// Loads a bubble on reset, then captures the
// execute stage payload on every clock edge.
//------------------------------------------------

`timescale 1ns/1ps

module exMemReg #(
    parameter logic [exPkg::DataWidth-1:0] ResetPc = '0 // PC held in reset.
) (
    input  logic             Clock,
    input  logic             arstN,
    input  exPkg::exResult_t nextResult,
    output exPkg::exResult_t exMem
);

    exPkg::exResult_t bubble;

    // All controls clear, program counter parked.
    always_comb begin
        bubble       = '0;
        bubble.pcOut = ResetPc;
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            exMem <= bubble;
        end else begin
            exMem <= nextResult; // No stalls, new payload each cycle.
        end
    end

endmodule

// ==== hw/exStage.sv ====
//------------------------------------------------
// Execute stage top level.
// Operand select, ALU, multiply-accumulate unit,
// control and the EX/MEM pipeline register.
//------------------------------------------------

`timescale 1ns/1ps

module exStage #(
    parameter logic [exPkg::DataWidth-1:0] ResetPc = '0
) (
    input  logic                        Clock,
    input  logic                        arstN,
    input  exPkg::exCtrl_t              ctrl,      // Decoded controls.
    input  logic [exPkg::DataWidth-1:0] a,         // Register A.
    input  logic [exPkg::DataWidth-1:0] b,         // Register B.
    input  logic [exPkg::DataWidth-1:0] immediate, // Sign-extended.
    input  logic [exPkg::DataWidth-1:0] pcIn,
    input  logic [4:0]                  shamt,
    input  logic [4:0]                  rAddrIn,
    output exPkg::exResult_t            exMem
);

    logic [exPkg::DataWidth-1:0] y;
    logic [exPkg::DataWidth-1:0] aluOut;
    logic [exPkg::DataWidth-1:0] accOut;
    exPkg::exFlags_t             aluFlags;
    exPkg::exFlags_t             accFlags;
    logic                        accEn;
    exPkg::exResult_t            nextResult;

    assign y = ctrl.aluSrc ? immediate : b; // Operand select.

    exAlu uAlu (
        .a        (a        ),
        .y        (y        ),
        .shamt    (shamt    ),
        .func     (ctrl.func),
        .aluOut   (aluOut   ),
        .aluFlags (aluFlags )
    );

    exMulAccum uMulAccum (
        .Clock    (Clock    ),
        .arstN    (arstN    ),
        .accEn    (accEn    ),
        .func     (ctrl.func),
        .a        (a        ),
        .y        (y        ),
        .accOut   (accOut   ),
        .accFlags (accFlags )
    );

    exControl uControl (
        .ctrl       (ctrl      ),
        .pcIn       (pcIn      ),
        .immediate  (immediate ),
        .b          (b         ),
        .rAddrIn    (rAddrIn   ),
        .aluOut     (aluOut    ),
        .aluFlags   (aluFlags  ),
        .accOut     (accOut    ),
        .accFlags   (accFlags  ),
        .accEn      (accEn     ),
        .nextResult (nextResult)
    );

    exMemReg #(
        .ResetPc (ResetPc)
    ) uMemReg (
        .Clock      (Clock     ),
        .arstN      (arstN     ),
        .nextResult (nextResult),
        .exMem      (exMem     )
    );

endmodule

// ==== verification/exChecker.sv ====
//------------------------------------------------
// Execute stage checker.
// Delays expected values one cycle, compares them
// with exMem, models random ALU rows itself.
//------------------------------------------------

`timescale 1ns/1ps

module exChecker #(
    parameter logic [31:0] ResetPc = '0
) (
    input  logic             Clock,
    input  logic             arstN,
    input  logic             valid,
    input  logic             done,
    input  int               rowIdx,
    input  logic             rnd,
    input  exPkg::exCtrl_t   ctrl,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    input  logic [31:0]      pcIn,
    input  logic [4:0]       rAddrIn,
    input  logic [31:0]      expRes,
    input  logic [3:0]       expFlags,
    input  logic             expTaken,
    input  logic [31:0]      expPc,
    input  logic             expRegWrite,
    input  exPkg::exResult_t exMem,
    output int               errorCount
);

    exPkg::exCtrl_t pCtrl;
    logic [31:0]    pA;
    logic [31:0]    pB;
    logic [31:0]    pPc;
    logic [31:0]    pRes;
    logic [31:0]    pExpPc;
    logic [31:0]    eRes;
    logic [31:0]    ePc;
    logic [4:0]     pRAddr;
    logic [3:0]     pFl;
    logic [3:0]     eFl;
    logic           pTaken;
    logic           pRw;
    logic           pRnd;
    logic           pValid;
    logic           eTaken;
    logic           eRw;
    logic           seen;
    logic           left;     // exMem moved off the reset bubble.
    logic           reported;
    logic [35:0]    model;
    int             pIdx;
    int             rowErrors;
    int             checkCount;
    int             passCount;

    initial begin
        errorCount = 0;
        checkCount = 0;
        passCount  = 0;
        seen       = 1'b0;
        left       = 1'b0;
        reported   = 1'b0;
        pValid     = 1'b0;
    end

    // Reference ALU for random rows, returns {c, z, o, n, result}.
    function automatic logic [35:0] aluModel(input exPkg::exFunc_e f, input logic [31:0] x,
                                             input logic [31:0] y);
        logic [32:0]        wide;
        logic signed [32:0] sw;
        logic [31:0]        r;
        logic               c;
        logic               o;
        c = 1'b0;
        o = 1'b0;
        case (f)
            exPkg::FnAdd, exPkg::FnAddu: begin
                wide = {1'b0, x} + {1'b0, y};
                r    = wide[31:0];
                c    = wide[32];
                sw   = $signed({x[31], x}) + $signed({y[31], y});
                o    = (f == exPkg::FnAdd) && (sw[32] != sw[31]);
            end
            exPkg::FnSub, exPkg::FnSubu: begin
                r  = x - y;
                c  = (x >= y); // No borrow.
                sw = $signed({x[31], x}) - $signed({y[31], y});
                o  = (f == exPkg::FnSub) && (sw[32] != sw[31]);
            end
            exPkg::FnSlt:  r = 32'($signed(x) < $signed(y));
            exPkg::FnSltu: r = 32'(x < y);
            exPkg::FnXor:  r = x ^ y;
            default:       r = ~(x | y);
        endcase
        return {c, (r == '0), o, r[31], r};
    endfunction

    task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("FAILED t=%0t row %0d %s expected %h got %h", $time, pIdx, name, exp, got);
            errorCount++;
            rowErrors++;
        end
    endtask

    // Inputs of the row that exMem will hold after this edge.
    always @(posedge Clock) begin
        pValid <= valid & arstN;
        pCtrl  <= ctrl;
        pA     <= a;
        pB     <= b;
        pPc    <= pcIn;
        pRAddr <= rAddrIn;
        pRes   <= expRes;
        pFl    <= expFlags;
        pTaken <= expTaken;
        pExpPc <= expPc;
        pRw    <= expRegWrite;
        pRnd   <= rnd;
        pIdx   <= rowIdx;
    end

    always @(negedge Clock) begin
        rowErrors = 0;
        if (pValid) begin
            seen = 1'b1;
            if (exMem.pcOut !== ResetPc) begin
                left = 1'b1;
            end
            if (pRnd) begin
                model  = aluModel(pCtrl.func, pA, pB);
                eRes   = model[31:0];
                eFl    = model[35:32];
                eTaken = 1'b0;
                ePc    = pPc + 32'd4;
                eRw    = pCtrl.regWrite;
            end else begin
                eRes   = pRes;
                eFl    = pFl;
                eTaken = pTaken;
                ePc    = pExpPc;
                eRw    = pRw;
            end
            checkField("result", eRes, exMem.result);
            checkField("flags", 32'(eFl), 32'(exMem.flags));
            checkField("branchTaken", 32'(eTaken), 32'(exMem.branchTaken));
            checkField("pcOut", ePc, exMem.pcOut);
            checkField("regWrite", 32'(eRw), 32'(exMem.regWrite));
            checkField("rtData", pB, exMem.rtData);
            checkField("rAddr", 32'(pRAddr), 32'(exMem.rAddr));
            checkField("memRead", 32'(pCtrl.memRead), 32'(exMem.memRead));
            checkField("memToReg", 32'(pCtrl.memToReg), 32'(exMem.memToReg));
            checkField("memWrite", 32'(pCtrl.memWrite), 32'(exMem.memWrite));
            checkCount++;
            if (rowErrors == 0) begin
                passCount++;
                $display("row %0d ok", pIdx);
            end else begin
                $display("row %0d had %0d errors", pIdx, rowErrors);
            end
        end else if (!seen) begin
            // Reset bubble.
            checkField("reset result", 32'h0, exMem.result);
            checkField("reset pcOut", ResetPc, exMem.pcOut);
            checkField("reset regWrite", 32'h0, 32'(exMem.regWrite));
            checkField("reset memRead", 32'h0, 32'(exMem.memRead));
            checkField("reset memWrite", 32'h0, 32'(exMem.memWrite));
            checkField("reset memToReg", 32'h0, 32'(exMem.memToReg));
            checkField("reset branchTaken", 32'h0, 32'(exMem.branchTaken));
        end
        if (done && !reported) begin
            if (!left) begin
                $display("exMem stayed at its reset value for the whole run");
                errorCount++;
            end
            $display("Checked %0d rows, %0d passed, %0d errors", checkCount, passCount, errorCount);
            reported = 1'b1;
        end
    end

endmodule

// ==== verification/exStageTb.sv ====
//------------------------------------------------
// Execute stage testbench.
// Clock, reset, stimulus table with LFSR operands,
// back-to-back row loop and watchdog.
//------------------------------------------------

`timescale 1ns/1ps

module exStageTb;

    localparam int NumRows = 40;
    localparam logic [31:0] ResetPc = 32'h0000_0100;
    localparam int LimitNs = (8 + NumRows + 20) * 10; // Reset, rows and slack.

    typedef struct packed {
        exPkg::exCtrl_t ctrl;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    imm;
        logic [31:0]    pc;
        logic [4:0]     shamt;
        logic [4:0]     rAddr;
        logic [31:0]    expRes;
        logic [3:0]     expFlags;   // c, z, o, n.
        logic           expTaken;
        logic [31:0]    expPc;
        logic           expRegWrite;
        logic           rnd;        // Checker models this row.
    } row_t;

    logic             Clock;
    logic             arstN;
    exPkg::exCtrl_t   ctrl;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      immediate;
    logic [31:0]      pcIn;
    logic [4:0]       shamt;
    logic [4:0]       rAddrIn;
    exPkg::exResult_t exMem;
    logic             valid;
    logic             done;
    int               rowIdx;
    int               errorCount;
    int               rowCount;
    logic [31:0]      lfsr;
    row_t             cur;
    row_t             rows [NumRows];

    exStage #(.ResetPc(ResetPc)) u_dut (
        .Clock(Clock), .arstN(arstN), .ctrl(ctrl), .a(a), .b(b), .immediate(immediate),
        .pcIn(pcIn), .shamt(shamt), .rAddrIn(rAddrIn), .exMem(exMem)
    );

    exChecker #(.ResetPc(ResetPc)) uChecker (
        .Clock(Clock), .arstN(arstN), .valid(valid), .done(done), .rowIdx(rowIdx),
        .rnd(cur.rnd), .ctrl(ctrl), .a(a), .b(b), .pcIn(pcIn), .rAddrIn(rAddrIn),
        .expRes(cur.expRes), .expFlags(cur.expFlags), .expTaken(cur.expTaken),
        .expPc(cur.expPc), .expRegWrite(cur.expRegWrite), .exMem(exMem),
        .errorCount(errorCount)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic randWord(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            w[i] = lfsr[0];
            lfsr = lfsrStep(lfsr);
        end
    endtask

    // ------------------------------------------------
    // Table building
    // ------------------------------------------------

    task automatic addRow(input exPkg::exFunc_e f, input logic [31:0] ra, input logic [31:0] rb,
                          input logic [31:0] rImm, input logic src, input logic [4:0] sh,
                          input logic [31:0] res, input logic [3:0] fl);
        row_t r;
        r = '0;
        r.ctrl.regWrite = 1'b1;
        r.ctrl.aluSrc   = src;
        r.ctrl.branch   = exPkg::BrNone;
        r.ctrl.func     = f;
        r.a             = ra;
        r.b             = rb;
        r.imm           = rImm;
        r.shamt         = sh;
        r.pc            = 32'h1000 + 32'(rowCount * 4);
        r.rAddr         = 5'(rowCount);
        r.expRes        = res;
        r.expFlags      = fl;
        r.expPc         = r.pc + 32'd4;  // Sequential flow.
        r.expRegWrite   = 1'b1;
        rows[rowCount]  = r;
        rowCount++;
    endtask

    task automatic setBranch(input exPkg::branchKind_e k, input logic [31:0] pc,
                             input logic [31:0] rImm, input logic tk, input logic [31:0] nextPc);
        rows[rowCount-1].ctrl.branch = k;
        rows[rowCount-1].pc          = pc;
        rows[rowCount-1].imm         = rImm;
        rows[rowCount-1].expTaken    = tk;
        rows[rowCount-1].expPc       = nextPc;
        rows[rowCount-1].expRegWrite = 1'b0; // Branches never write back.
    endtask

    task automatic setMem(input logic rd, input logic m2r, input logic wr);
        rows[rowCount-1].ctrl.memRead  = rd;
        rows[rowCount-1].ctrl.memToReg = m2r;
        rows[rowCount-1].ctrl.memWrite = wr;
    endtask

    task automatic addRandom(input exPkg::exFunc_e f);
        logic [31:0] ra;
        logic [31:0] rb;
        randWord(ra);
        randWord(rb);
        addRow(f, ra, rb, 32'h0, 1'b0, 5'd0, 32'h0, 4'b0);
        rows[rowCount-1].rnd = 1'b1;
    endtask

    task automatic buildTable();
        // Arithmetic corners.
        addRow(exPkg::FnAdd,  32'h7FFF_FFFF, 32'h1, 32'h0, 1'b0, 5'd0, 32'h8000_0000, 4'b0011);
        addRow(exPkg::FnAddu, 32'h7FFF_FFFF, 32'h1, 32'h0, 1'b0, 5'd0, 32'h8000_0000, 4'b0001);
        addRow(exPkg::FnAddu, 32'hFFFF_FFFF, 32'h1, 32'h0, 1'b0, 5'd0, 32'h0, 4'b1100);
        addRow(exPkg::FnSub,  32'h0, 32'h1, 32'h0, 1'b0, 5'd0, 32'hFFFF_FFFF, 4'b0001);
        addRow(exPkg::FnSubu, 32'h5, 32'h5, 32'h0, 1'b0, 5'd0, 32'h0, 4'b1100);
        addRow(exPkg::FnSlt,  32'hFFFF_FFFF, 32'h1, 32'h0, 1'b0, 5'd0, 32'h1, 4'b0000);
        addRow(exPkg::FnSltu, 32'hFFFF_FFFF, 32'h1, 32'h0, 1'b0, 5'd0, 32'h0, 4'b0100);
        addRow(exPkg::FnSub,  32'h8000_0000, 32'h1, 32'h0, 1'b0, 5'd0, 32'h7FFF_FFFF, 4'b1010);
        addRow(exPkg::FnSubu, 32'h8000_0000, 32'h1, 32'h0, 1'b0, 5'd0, 32'h7FFF_FFFF, 4'b1000);
        // Logic, shifts, operand select.
        addRow(exPkg::FnAnd, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0, 1'b0, 5'd0, 32'hF000_F000, 4'b0001);
        setMem(1'b1, 1'b1, 1'b0);
        addRow(exPkg::FnOr, 32'h0F00_0000, 32'h1234_5678, 32'hFF, 1'b1, 5'd0, 32'h0F00_00FF, 4'b0);
        setMem(1'b0, 1'b0, 1'b1);
        addRow(exPkg::FnXor,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 1'b0, 5'd0, 32'h0, 4'b0100);
        addRow(exPkg::FnNor,  32'h0, 32'h9, 32'hFFFF_0000, 1'b1, 5'd0, 32'h0000_FFFF, 4'b0000);
        addRow(exPkg::FnSll,  32'h0, 32'hF, 32'h0, 1'b0, 5'd4, 32'hF0, 4'b0000);
        addRow(exPkg::FnSrl,  32'h0, 32'h8000_0000, 32'h0, 1'b0, 5'd4, 32'h0800_0000, 4'b0000);
        addRow(exPkg::FnSra,  32'h0, 32'h8000_0000, 32'h0, 1'b0, 5'd4, 32'hF800_0000, 4'b0001);
        addRow(exPkg::FnSllv, 32'h8, 32'h1, 32'h0, 1'b0, 5'd0, 32'h100, 4'b0000);
        addRow(exPkg::FnSrlv, 32'h24, 32'hF0, 32'h0, 1'b0, 5'd0, 32'hF, 4'b0000);
        addRow(exPkg::FnSrav, 32'h1F, 32'h55, 32'h8000_0000, 1'b1, 5'd0, 32'hFFFF_FFFF, 4'b0001);
        addRow(exPkg::FnLui,  32'h0, 32'hDEAD, 32'h1234, 1'b1, 5'd0, 32'h1234_0000, 4'b0000);
        // Multiply-accumulate, HI/LO = -6, then + 2^32, then (2^32 - 1) squared.
        addRow(exPkg::FnMult,  32'hFFFF_FFFE, 32'h3, 32'h0, 1'b0, 5'd0, 32'hFFFF_FFFA, 4'b0001);
        addRow(exPkg::FnMflo,  32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 32'hFFFF_FFFA, 4'b0001);
        addRow(exPkg::FnMfhi,  32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 32'hFFFF_FFFF, 4'b0001);
        addRow(exPkg::FnMadd,  32'h1_0000, 32'h1_0000, 32'h0, 1'b0, 5'd0, 32'hFFFF_FFFA, 4'b0);
        addRow(exPkg::FnMflo,  32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 32'hFFFF_FFFA, 4'b0000);
        addRow(exPkg::FnMfhi,  32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0, 4'b0000);
        addRow(exPkg::FnMultu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 1'b0, 5'd0, 32'h1, 4'b0001);
        addRow(exPkg::FnMfhi,  32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 32'hFFFF_FFFE, 4'b0001);
        // Branches and jump.
        addRow(exPkg::FnSub, 32'h5, 32'h5, 32'h0, 1'b0, 5'd0, 32'h0, 4'b1100);
        setBranch(exPkg::BrEq, 32'h200, 32'h10, 1'b1, 32'h244);
        addRow(exPkg::FnSub, 32'h5, 32'h6, 32'h0, 1'b0, 5'd0, 32'hFFFF_FFFF, 4'b0001);
        setBranch(exPkg::BrEq, 32'h200, 32'h10, 1'b0, 32'h204);
        addRow(exPkg::FnSub, 32'h5, 32'h6, 32'h0, 1'b0, 5'd0, 32'hFFFF_FFFF, 4'b0001);
        setBranch(exPkg::BrNe, 32'h200, 32'hFFFF_FFFC, 1'b1, 32'h1F4);
        addRow(exPkg::FnAdd, 32'h0, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0, 4'b0100);
        setBranch(exPkg::BrJump, 32'h300, 32'h0040_0000, 1'b1, 32'h0040_0000);
        // LFSR operands.
        addRandom(exPkg::FnAdd);
        addRandom(exPkg::FnAddu);
        addRandom(exPkg::FnSub);
        addRandom(exPkg::FnSubu);
        addRandom(exPkg::FnSlt);
        addRandom(exPkg::FnSltu);
        addRandom(exPkg::FnXor);
        addRandom(exPkg::FnNor);
    endtask

    task automatic applyRow(input int i);
        ctrl      = rows[i].ctrl;
        a         = rows[i].a;
        b         = rows[i].b;
        immediate = rows[i].imm;
        pcIn      = rows[i].pc;
        shamt     = rows[i].shamt;
        rAddrIn   = rows[i].rAddr;
        cur       = rows[i];
        rowIdx    = i;
        valid     = 1'b1;
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------

    initial begin
        arstN     = 1'b0;
        ctrl      = '0;
        a         = '0;
        b         = '0;
        immediate = '0;
        pcIn      = '0;
        shamt     = '0;
        rAddrIn   = '0;
        valid     = 1'b0;
        done      = 1'b0;
        rowIdx    = 0;
        rowCount  = 0;
        cur       = '0;
        lfsr      = 32'd93;
        buildTable();
        repeat (8) @(posedge Clock);
        #1;
        arstN = 1'b1;
        for (int i = 0; i < NumRows; i++) begin
            if (i > 0) begin
                @(posedge Clock);
                #1;
            end
            applyRow(i); // One row per cycle, no gaps.
        end
        @(posedge Clock);
        #1;
        valid = 1'b0;
        @(posedge Clock);
        #1;
        done = 1'b1;
        @(negedge Clock);
        #1;
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(LimitNs);
        $display("Timeout: the run did not finish within %0d ns", LimitNs);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/exPkg.sv
hw/exAlu.sv
hw/exMulAccum.sv
hw/exControl.sv
hw/exMemReg.sv
hw/exStage.sv
verification/exChecker.sv
verification/exStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module exStageTb -o exStageSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/exStageSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "Simulation log has no pass line"
    exit 1
fi
exit 0
